// ==== verilog/icache_pkg.sv ====
// shared geometry, address views and channel types for the instruction cache
`default_nettype none

package icache_pkg;

    //////////////////////////////////////////////////
    // geometry
    //////////////////////////////////////////////////
    localparam int INDEX_W    = 4;
    localparam int OFFSET_W   = 2;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = 128;
    localparam int TAG_W      = 24;
    localparam int SETS       = 16;

    // field view of a byte address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
        logic [1:0]          byte_sel;
    } addr_fields_t;

    // one word, read as raw address or as cache fields
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } fetch_addr_u;

    //////////////////////////////////////////////////
    // channels
    //////////////////////////////////////////////////
    typedef struct packed {
        fetch_addr_u addr;
        logic        inval;
    } fetch_req_t;

    // low word of instr is the one at pc
    typedef struct packed {
        logic [31:0] pc;
        logic [63:0] instr;
        logic        second_ok;
    } fetch_resp_t;

    // line aligned, low 4 bits zero
    typedef struct packed {
        logic [31:0] addr;
    } mem_req_t;

    typedef logic [LINE_W-1:0] line_t;

endpackage

`default_nettype wire

// ==== verilog/icache_tag_array.sv ====
// two-way tag store with valid bits; registered read index and per-way hit compare
`default_nettype none
`timescale 1ns/100ps

module icache_tag_array (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [icache_pkg::INDEX_W-1:0] rd_index,
    input  logic [icache_pkg::TAG_W-1:0]   cmp_tag,
    output logic [1:0]                     hit,
    input  logic [1:0]                     wr_en,
    input  logic [icache_pkg::INDEX_W-1:0] wr_index,
    input  logic [icache_pkg::TAG_W-1:0]   wr_tag,
    input  logic                           inval_en,
    input  logic [icache_pkg::INDEX_W-1:0] inval_index
);
    import icache_pkg::*;

    logic [TAG_W-1:0]      tag_mem [2][SETS];
    logic [1:0][SETS-1:0]  valid_q;
    logic [INDEX_W-1:0]    rd_index_q;

    // tag storage, no reset
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wr_en[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= '0;
            rd_index_q <= '0;
        end else begin
            rd_index_q <= rd_index;
            for (int w = 0; w < 2; w++) begin
                if (wr_en[w]) begin
                    valid_q[w][wr_index] <= 1'b1;
                end
            end
            // invalidate wins over a fill to the same set
            if (inval_en) begin
                valid_q[0][inval_index] <= 1'b0;
                valid_q[1][inval_index] <= 1'b0;
            end
        end
    end

    // compare against the set read last edge
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = valid_q[w][rd_index_q] && (tag_mem[w][rd_index_q] == cmp_tag);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/icache_data_array.sv ====
// two-way line store; synchronous read of both ways, whole-line write per way
`default_nettype none
`timescale 1ns/100ps

module icache_data_array (
    input  logic                           clk,
    input  logic [icache_pkg::INDEX_W-1:0] rd_index,
    output icache_pkg::line_t              rd_line0,
    output icache_pkg::line_t              rd_line1,
    input  logic [1:0]                     wr_en,
    input  logic [icache_pkg::INDEX_W-1:0] wr_index,
    input  icache_pkg::line_t              wr_line
);
    import icache_pkg::*;

    line_t mem [2][SETS];

    // refill writes a full line into one way
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wr_en[w]) begin
                mem[w][wr_index] <= wr_line;
            end
        end
    end

    // both ways read every cycle, old data on a same-set write
    always_ff @(posedge clk) begin
        rd_line0 <= mem[0][rd_index];
        rd_line1 <= mem[1][rd_index];
    end

endmodule

`default_nettype wire

// ==== verilog/icache_lru.sv ====
// per-set LRU bit for two ways; names the victim way of the buffered set
`default_nettype none
`timescale 1ns/100ps

module icache_lru (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [icache_pkg::INDEX_W-1:0] rd_index,
    output logic                           victim,
    input  logic                           use_valid,
    input  logic [icache_pkg::INDEX_W-1:0] use_index,
    input  logic                           use_way
);
    import icache_pkg::*;

    // bit set means way 1 is least recently used
    logic [SETS-1:0] lru_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (use_valid) begin
            lru_q[use_index] <= ~use_way;
        end
    end

    assign victim = lru_q[rd_index];

endmodule

`default_nettype wire

// ==== verilog/icache_ctrl.sv ====
// request buffer and lookup/refill FSM; drives handshakes, array writes and output select
`default_nettype none
`timescale 1ns/100ps

module icache_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req_valid,
    output logic                            req_ready,
    input  icache_pkg::fetch_req_t          req,
    output logic                            resp_valid,
    input  logic                            resp_ready,
    output icache_pkg::fetch_addr_u         pc,
    output logic                            mem_req_valid,
    input  logic                            mem_req_ready,
    output icache_pkg::mem_req_t            mem_req,
    input  logic                            mem_resp_valid,
    output logic [icache_pkg::INDEX_W-1:0]  rd_index,
    output logic [icache_pkg::TAG_W-1:0]    cmp_tag,
    input  logic [1:0]                      hit,
    input  logic                            victim,
    output logic [1:0]                      tag_wr_en,
    output logic [1:0]                      data_wr_en,
    output logic [icache_pkg::INDEX_W-1:0]  wr_index,
    output logic [icache_pkg::TAG_W-1:0]    wr_tag,
    output logic                            inval_en,
    output logic                            lru_use_valid,
    output logic                            lru_use_way,
    output logic                            sel_way,
    output logic                            sel_refill,
    output logic [icache_pkg::OFFSET_W-1:0] word_offset,
    output logic                            hold
);
    import icache_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_MISS_REQ,
        S_REFILL,
        S_INVAL
    } state_t;

    state_t     state_q;
    state_t     state_d;
    fetch_req_t buf_q;
    logic       lk_valid_q;
    logic       lk_valid_d;
    logic       held_q;
    logic       lookup;
    logic       hit_any;
    logic       fill;
    logic       accept;
    logic       resp_fire;
    logic [1:0] fill_way;

    //////////////////////////////////////////////////
    // handshakes
    //////////////////////////////////////////////////
    assign lookup  = (state_q == S_IDLE) && lk_valid_q;
    assign hit_any = |hit;
    assign fill    = (state_q == S_REFILL) && mem_resp_valid;

    // a held response stays valid whatever the arrays now return
    assign resp_valid = (lookup && (held_q || hit_any)) || fill;
    assign resp_fire  = resp_valid && resp_ready;

    // idle, or the pending response leaves this cycle
    assign req_ready = (state_q == S_IDLE) && (!lk_valid_q || resp_fire);
    assign accept    = req_valid && req_ready;

    assign mem_req_valid = (state_q == S_MISS_REQ);
    assign mem_req.addr  = {buf_q.addr.f.tag, buf_q.addr.f.index, {(OFFSET_W + 2){1'b0}}};

    //////////////////////////////////////////////////
    // array side
    //////////////////////////////////////////////////
    // new index on the accept edge, else keep the buffered set
    assign rd_index = accept ? req.addr.f.index : buf_q.addr.f.index;
    assign cmp_tag  = buf_q.addr.f.tag;
    assign wr_index = buf_q.addr.f.index;
    assign wr_tag   = buf_q.addr.f.tag;

    assign fill_way   = {victim, ~victim};
    assign tag_wr_en  = fill ? fill_way : 2'b00;
    assign data_wr_en = fill ? fill_way : 2'b00;
    assign inval_en   = (state_q == S_INVAL);

    // LRU touched once per hit, and on the fill
    assign lru_use_valid = (lookup && hit_any && !held_q) || fill;
    assign lru_use_way   = sel_way;

    // output stage select
    assign sel_refill  = (state_q == S_REFILL);
    assign sel_way     = sel_refill ? victim : hit[1];
    assign word_offset = buf_q.addr.f.offset;
    assign hold        = held_q;
    assign pc          = buf_q.addr;

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////
    always_comb begin
        state_d    = state_q;
        lk_valid_d = lk_valid_q;
        case (state_q)
            S_IDLE: begin
                if (resp_fire) begin
                    lk_valid_d = 1'b0;
                end
                if (lookup && !held_q && !hit_any) begin
                    state_d    = S_MISS_REQ;
                    lk_valid_d = 1'b0;
                end
                if (accept) begin
                    lk_valid_d = !req.inval;
                    if (req.inval) begin
                        state_d = S_INVAL;
                    end
                end
            end
            S_MISS_REQ: begin
                if (mem_req_ready) begin
                    state_d = S_REFILL;
                end
            end
            S_REFILL: begin
                // an untaken refill response waits in idle as a held lookup
                if (mem_resp_valid) begin
                    state_d    = S_IDLE;
                    lk_valid_d = !resp_ready;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            lk_valid_q <= 1'b0;
            held_q     <= 1'b0;
        end else begin
            state_q    <= state_d;
            lk_valid_q <= lk_valid_d;
            held_q     <= resp_valid && !resp_ready;
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            buf_q <= req;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/icache_fetch_out.sv ====
// picks the line and word pair for the response and holds it under back-pressure
`default_nettype none
`timescale 1ns/100ps

module icache_fetch_out (
    input  logic                            clk,
    input  logic                            rst_n,
    input  icache_pkg::line_t               line0,
    input  icache_pkg::line_t               line1,
    input  icache_pkg::line_t               refill_line,
    input  logic                            sel_way,
    input  logic                            sel_refill,
    input  logic [icache_pkg::OFFSET_W-1:0] word_offset,
    input  logic                            hold,
    input  icache_pkg::fetch_addr_u         pc,
    output icache_pkg::fetch_resp_t         resp
);
    import icache_pkg::*;

    line_t       line_sel;
    logic [63:0] pair;
    logic        second_ok;
    logic [64:0] pair_q;

    always_comb begin
        if (sel_refill) begin
            line_sel = refill_line;
        end else if (sel_way) begin
            line_sel = line1;
        end else begin
            line_sel = line0;
        end
    end

    // second word only usable when it sits in the same line
    always_comb begin
        if (!word_offset[0]) begin
            pair      = line_sel[{word_offset[1], 6'b0} +: 64];
            second_ok = 1'b1;
        end else begin
            pair      = {32'h0, line_sel[{word_offset, 5'b0} +: 32]};
            second_ok = 1'b0;
        end
    end

    // tracks the live pair until hold rises, then freezes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_q <= '0;
        end else if (!hold) begin
            pair_q <= {pair, second_ok};
        end
    end

    assign resp.pc = pc.raw;
    assign {resp.instr, resp.second_ok} = hold ? pair_q : {pair, second_ok};

endmodule

`default_nettype wire

// ==== verilog/icache.sv ====
// top of the two-way instruction cache; connects arrays, LRU, FSM and output stage
`default_nettype none
`timescale 1ns/100ps

module icache (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  icache_pkg::fetch_req_t  req,
    output logic                    resp_valid,
    input  logic                    resp_ready,
    output icache_pkg::fetch_resp_t resp,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output icache_pkg::mem_req_t    mem_req,
    input  logic                    mem_resp_valid,
    input  icache_pkg::line_t       mem_resp_line
);
    import icache_pkg::*;

    logic [INDEX_W-1:0]  rd_index;
    logic [INDEX_W-1:0]  wr_index;
    logic [TAG_W-1:0]    cmp_tag;
    logic [TAG_W-1:0]    wr_tag;
    logic [1:0]          hit;
    logic [1:0]          tag_wr_en;
    logic [1:0]          data_wr_en;
    logic                inval_en;
    logic                victim;
    logic                lru_use_valid;
    logic                lru_use_way;
    logic                sel_way;
    logic                sel_refill;
    logic [OFFSET_W-1:0] word_offset;
    logic                hold;
    line_t               line0;
    line_t               line1;
    fetch_addr_u         pc;

    icache_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .pc(pc),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
        .mem_resp_valid(mem_resp_valid),
        .rd_index(rd_index), .cmp_tag(cmp_tag), .hit(hit), .victim(victim),
        .tag_wr_en(tag_wr_en), .data_wr_en(data_wr_en),
        .wr_index(wr_index), .wr_tag(wr_tag), .inval_en(inval_en),
        .lru_use_valid(lru_use_valid), .lru_use_way(lru_use_way),
        .sel_way(sel_way), .sel_refill(sel_refill),
        .word_offset(word_offset), .hold(hold)
    );

    // invalidate shares the buffered index with the fill path
    icache_tag_array u_tag (
        .clk(clk), .rst_n(rst_n),
        .rd_index(rd_index), .cmp_tag(cmp_tag), .hit(hit),
        .wr_en(tag_wr_en), .wr_index(wr_index), .wr_tag(wr_tag),
        .inval_en(inval_en), .inval_index(wr_index)
    );

    icache_data_array u_data (
        .clk(clk),
        .rd_index(rd_index), .rd_line0(line0), .rd_line1(line1),
        .wr_en(data_wr_en), .wr_index(wr_index), .wr_line(mem_resp_line)
    );

    icache_lru u_lru (
        .clk(clk), .rst_n(rst_n),
        .rd_index(wr_index), .victim(victim),
        .use_valid(lru_use_valid), .use_index(wr_index), .use_way(lru_use_way)
    );

    icache_fetch_out u_out (
        .clk(clk), .rst_n(rst_n),
        .line0(line0), .line1(line1), .refill_line(mem_resp_line),
        .sel_way(sel_way), .sel_refill(sel_refill),
        .word_offset(word_offset), .hold(hold),
        .pc(pc), .resp(resp)
    );

endmodule

`default_nettype wire

// ==== verification/icache_mem_model.sv ====
// refill memory for the cache testbench; random accept and data delays, line data from the address
`default_nettype none
`timescale 1ns/100ps

module icache_mem_model (
    input  logic                 clk,
    input  logic                 mem_req_valid,
    output logic                 mem_req_ready,
    input  icache_pkg::mem_req_t mem_req,
    output logic                 mem_resp_valid,
    output icache_pkg::line_t    mem_resp_line
);
    import icache_pkg::*;

    localparam int MAX_DELAY = 6;

    logic [31:0] line_addr;
    int unsigned wait_cycles;

    // each word is its own byte address xor a fixed pattern
    function automatic line_t make_line(input logic [31:0] base);
        line_t line;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line[32*i +: 32] = (base + 32'(4 * i)) ^ 32'hA5A5_0000;
        end
        return line;
    endfunction

    initial begin
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_line  = '0;
        line_addr      = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req_valid) begin
                // accept after a random wait
                wait_cycles = $urandom_range(MAX_DELAY, 0);
                repeat (wait_cycles) begin
                    @(posedge clk);
                    #1;
                end
                line_addr     = mem_req.addr;
                mem_req_ready = 1'b1;
                @(posedge clk);
                #1;
                mem_req_ready = 1'b0;
                // data latency, zero means the cycle right after the accept
                wait_cycles = $urandom_range(MAX_DELAY, 0);
                if (wait_cycles != 0) begin
                    repeat (wait_cycles) @(posedge clk);
                    #1;
                end
                mem_resp_valid = 1'b1;
                mem_resp_line  = make_line(line_addr);
                @(posedge clk);
                #1;
                mem_resp_valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/icache_tb.sv ====
// testbench for the instruction cache; issues fetches and invalidates and checks every response
`default_nettype none
`timescale 1ns/100ps

module icache_tb;
    import icache_pkg::*;

    localparam logic [31:0] SEED = 32'h06709206;
    localparam int N_SEQ      = 256;
    localparam int N_RAND     = 320;
    localparam int N_DIRECTED = 24;
    // worst miss with both memory delays plus a stall, per fetch
    localparam int FETCH_CYCLES   = 30;
    localparam int TIMEOUT_CYCLES = (N_SEQ + N_RAND + N_DIRECTED) * FETCH_CYCLES + 2000;

    // LRU lines share set 5, invalidate lines share set 3
    localparam logic [31:0] LRU_A = 32'h0000_8050;
    localparam logic [31:0] LRU_B = 32'h0000_8154;
    localparam logic [31:0] LRU_C = 32'h0000_8258;
    localparam logic [31:0] INV_X = 32'h0000_9038;
    localparam logic [31:0] INV_Y = 32'h0000_9130;

    typedef struct packed {
        logic [31:0] addr;
        logic        hit;
        logic [31:0] accept_cycle;
        logic [31:0] mem_at_accept;
    } fetch_entry_t;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic        req_ready;
    fetch_req_t  req;
    logic        resp_valid;
    logic        resp_ready;
    fetch_resp_t resp;
    logic        mem_req_valid;
    logic        mem_req_ready;
    mem_req_t    mem_req;
    logic        mem_resp_valid;
    line_t       mem_resp_line;

    logic             bp_enable;
    fetch_entry_t     exp_q[$];
    logic [TAG_W-1:0] model_tag [2][SETS];
    logic             model_valid [2][SETS];
    logic             model_lru [SETS];
    logic [31:0]      cycle;
    logic [31:0]      mem_reqs;
    logic [31:0]      seen_cycle;
    logic             seen;
    logic             stalled;
    fetch_resp_t      stalled_resp;
    logic             inval_check;
    int unsigned      fetch_count;
    int unsigned      resp_count;

    icache uut (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp(resp),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
        .mem_resp_valid(mem_resp_valid), .mem_resp_line(mem_resp_line)
    );

    icache_mem_model u_mem (
        .clk(clk),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
        .mem_resp_valid(mem_resp_valid), .mem_resp_line(mem_resp_line)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        fail_run($sformatf("FAILED %s got %0h expected %0h", name, got, exp));
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
        return {byte_addr[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [31:0] random_fetch_addr();
        return 32'h0000_1000 + 4 * $urandom_range(1023, 0);
    endfunction

    // tag in 31:8, set in 7:4; fills the LRU way on a miss
    function automatic logic model_lookup(input logic [31:0] a);
        logic [3:0]       idx;
        logic [TAG_W-1:0] tag;
        logic             way;
        logic             found;
        idx   = a[7:4];
        tag   = a[31:8];
        way   = 1'b0;
        found = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[w][idx] && model_tag[w][idx] == tag) begin
                found = 1'b1;
                way   = w[0];
            end
        end
        if (!found) begin
            way                   = model_lru[idx];
            model_tag[way][idx]   = tag;
            model_valid[way][idx] = 1'b1;
        end
        model_lru[idx] = ~way;
        return found;
    endfunction

    // ready is looked at mid-cycle, the transfer is the next rising edge
    task automatic send_req(input logic [31:0] addr, input logic inval);
        req_valid    = 1'b1;
        req.addr.raw = addr;
        req.inval    = inval;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (!inval) begin
            fetch_count = fetch_count + 1;
        end
    endtask

    //////////////////////////////////////////////////
    // per-edge checks
    //////////////////////////////////////////////////
    task automatic check_edge();
        logic [31:0]  exp_lo;
        logic [31:0]  exp_hi;
        logic         exp_sec;
        fetch_entry_t entry;
        if (stalled) begin
            assert (resp_valid) else fail_run("response dropped while resp_ready was low");
            assert (resp == stalled_resp) else report_mismatch("resp", resp, stalled_resp);
        end
        if (inval_check) begin
            assert (!req_ready && !resp_valid)
                else fail_run("cache was not busy in the invalidate cycle");
            inval_check = 1'b0;
        end
        if (resp_valid) begin
            assert (exp_q.size() != 0) else fail_run("response with no outstanding fetch");
            if (!seen) begin
                seen       = 1'b1;
                seen_cycle = cycle;
            end
        end
        if (mem_req_valid && mem_req_ready) begin
            mem_reqs = mem_reqs + 1;
            assert (exp_q.size() != 0 && !exp_q[0].hit)
                else fail_run("memory request without a predicted miss");
            assert (mem_req.addr == {exp_q[0].addr[31:4], 4'h0})
                else report_mismatch("mem_req.addr", mem_req.addr,
                                     {exp_q[0].addr[31:4], 4'h0});
        end
        if (resp_valid && resp_ready) begin
            entry      = exp_q.pop_front();
            resp_count = resp_count + 1;
            exp_lo     = mem_word(entry.addr);
            exp_sec    = !entry.addr[2];
            exp_hi     = exp_sec ? mem_word(entry.addr + 32'd4) : 32'h0;
            assert (resp.pc == entry.addr) else report_mismatch("resp.pc", resp.pc, entry.addr);
            assert (resp.second_ok == exp_sec)
                else report_mismatch("resp.second_ok", resp.second_ok, exp_sec);
            assert (resp.instr[31:0] == exp_lo)
                else report_mismatch("resp.instr[31:0]", resp.instr[31:0], exp_lo);
            assert (resp.instr[63:32] == exp_hi)
                else report_mismatch("resp.instr[63:32]", resp.instr[63:32], exp_hi);
            if (entry.hit) begin
                assert (seen_cycle == entry.accept_cycle + 1)
                    else fail_run("hit response did not come one cycle after its accept");
                assert (mem_reqs == entry.mem_at_accept)
                    else fail_run("memory request made for a predicted hit");
            end else begin
                assert (mem_reqs == entry.mem_at_accept + 1)
                    else fail_run("predicted miss did not make exactly one memory request");
            end
            seen = 1'b0;
        end
        stalled = resp_valid && !resp_ready;
        if (stalled) begin
            stalled_resp = resp;
            assert (!req_ready) else fail_run("request accepted while a response was stalled");
        end
        if (req_valid && req_ready) begin
            if (req.inval) begin
                model_valid[0][req.addr.raw[7:4]] = 1'b0;
                model_valid[1][req.addr.raw[7:4]] = 1'b0;
                inval_check = 1'b1;
            end else begin
                entry.addr          = req.addr.raw;
                entry.hit           = model_lookup(req.addr.raw);
                entry.accept_cycle  = cycle;
                entry.mem_at_accept = mem_reqs;
                exp_q.push_back(entry);
            end
        end
    endtask

    always @(negedge clk) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            fail_run("timeout, the run did not finish within the cycle limit");
        end else if (rst_n) begin
            check_edge();
        end
    end

    // random low stretches on resp_ready
    initial begin
        resp_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            resp_ready = !bp_enable || ($urandom_range(1, 0) == 0);
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(SEED));
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        bp_enable   = 1'b0;
        cycle       = '0;
        mem_reqs    = '0;
        seen_cycle  = '0;
        seen        = 1'b0;
        stalled     = 1'b0;
        inval_check = 1'b0;
        fetch_count = 0;
        resp_count  = 0;
        for (int s = 0; s < SETS; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_lru[s]      = 1'b0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (req_ready && !resp_valid && !mem_req_valid)
            else fail_run("cache outputs not at their reset values");

        // sequential fetches at full rate
        for (int i = 0; i < N_SEQ; i++) begin
            send_req(32'h0000_1000 + 4 * i, 1'b0);
        end

        // A B A C leaves B as the victim
        send_req(LRU_A, 1'b1);
        send_req(LRU_A, 1'b0);
        send_req(LRU_B, 1'b0);
        send_req(LRU_A, 1'b0);
        send_req(LRU_C, 1'b0);
        send_req(LRU_A, 1'b0);
        send_req(LRU_B, 1'b0);

        // both lines cached, then the set is cleared
        send_req(INV_X, 1'b0);
        send_req(INV_Y, 1'b0);
        send_req(INV_X, 1'b0);
        send_req(INV_Y, 1'b0);
        send_req(INV_X, 1'b1);
        send_req(INV_X, 1'b0);
        send_req(INV_Y, 1'b0);

        @(posedge clk);
        bp_enable = 1'b1;
        #1;
        for (int i = 0; i < N_RAND; i++) begin
            send_req(random_fetch_addr(), $urandom_range(31, 0) == 0);
        end

        @(posedge clk);
        bp_enable = 1'b0;
        #1;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        #1;
        if (exp_q.size() == 0 && resp_count == fetch_count) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            fail_run("number of responses differs from the number of fetches");
        end
    end

endmodule

`default_nettype wire

// ==== icache.f ====
verilog/icache_pkg.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_lru.sv
verilog/icache_ctrl.sv
verilog/icache_fetch_out.sv
verilog/icache.sv
verification/icache_mem_model.sv
verification/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the icache testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module icache_tb -f icache.f -o icache_sim
status=0
output=$(./obj_dir/icache_sim 2>&1) || status=$?
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "simulation did not pass, exit status $status"
exit 1
